// File: test/eeprom_stim.txt
# op addr wdata force_nack exp_rdata exp_nack, all hex, op 1 = write, 0 = read
# exp_rdata is zero on writes and whenever the slave refuses the control byte
1 015 a5 0 00 0
0 015 00 0 a5 0
1 115 3c 0 00 0
1 715 c3 0 00 0
0 015 00 0 a5 0
0 115 00 0 3c 0
0 715 00 0 c3 0
0 2ff 00 0 00 0
1 015 77 1 00 1
0 015 00 0 a5 0
0 115 00 1 00 1
1 4ff 5a 0 00 0
1 500 81 0 00 0
0 4ff 00 0 5a 0
0 500 00 0 81 0

// File: eeprom_ctrl.f
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/i2c_pkg.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_seq.sv
verilog/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/eeprom_ctrl_tb.sv

// File: Bender.yml
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/eeprom_pkg.sv
      - verilog/i2c_pkg.sv
      - verilog/i2c_bit_engine.sv
      - verilog/eeprom_seq.sv
      - verilog/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/eeprom_model.sv
      - test/eeprom_ctrl_tb.sv

// File: test/eeprom_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int ACCEPT_LIMIT = 2000;
    localparam int RSP_LIMIT    = 4000;

    logic    CLK;
    logic    RESET;
    logic    req_valid;
    ee_req_t req;
    logic    req_ready;
    logic    rsp_valid;
    ee_rsp_t rsp;
    logic    rsp_ready;
    logic    scl;
    logic    sda_oe;
    logic    sda;
    logic    slave_pull;
    logic    force_nack;

    logic [`EE_DATA_W-1:0] exp_mem [0:(1 << `EE_ADDR_W)-1];
    bit                    written [0:(1 << `EE_ADDR_W)-1];
    logic [31:0]           rand_state;
    int                    err_cnt;
    int                    timeout_cnt;
    int                    req_cnt;
    int                    rsp_cnt = 0;

    assign sda = !sda_oe && !slave_pull;   // open drain

    eeprom_ctrl_top dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_model eeprom (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack),
        .pull       (slave_pull)
    );

    always #10 CLK = !CLK;

    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid && rsp_ready)
            rsp_cnt <= rsp_cnt + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_rsp(input int idx, input ee_rsp_t got, input ee_rsp_t exp);
        if (got.rdata !== exp.rdata)
        begin
            $display("ERR rsp.rdata req %0d got=%h exp=%h", idx, got.rdata, exp.rdata);
            err_cnt++;
        end
        if (got.nack !== exp.nack)
        begin
            $display("ERR rsp.nack req %0d got=%h exp=%h", idx, got.nack, exp.nack);
            err_cnt++;
        end
    endtask

    task automatic check_mem(input logic [`EE_ADDR_W-1:0] addr,
                             input logic [`EE_DATA_W-1:0] exp);
        if (eeprom.mem[addr] !== exp)
        begin
            $display("ERR mem[%h] got=%h exp=%h", addr, eeprom.mem[addr], exp);
            err_cnt++;
        end
    endtask

    // bus must be stopped while a response waits
    task automatic check_bus_idle(input logic scl_v, input logic sda_v);
        if (scl_v !== 1'b1 || sda_v !== 1'b1)
        begin
            $display("ERR scl/sda got=%h/%h exp=1/1", scl_v, sda_v);
            err_cnt++;
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp)
        begin
            $display("ERR rsp_count got=%h exp=%h", got, exp);
            err_cnt++;
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_req(input ee_req_t r, output bit ok);
        int n;
        n         = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready && n < ACCEPT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        ok = req_ready;
        @(negedge CLK);   // transfer on the rising edge in between
        req_valid = 1'b0;
    endtask

    task automatic get_rsp(output ee_rsp_t r, output bit ok);
        int n;
        bit got;
        n   = 0;
        got = 1'b0;
        while (!got && n < RSP_LIMIT)
        begin
            rand_state = lcg_next(rand_state);
            rsp_ready  = rand_state[16];
            if (rsp_valid)
                check_bus_idle(scl, sda);
            if (rsp_valid && rsp_ready)
            begin
                got = 1'b1;
                r   = rsp;
            end
            else
            begin
                @(negedge CLK);
                n++;
            end
        end
        ok = got;
        @(negedge CLK);   // ready stays up so a repeated response gets counted
    endtask

    initial
    begin
        int                    fd;
        int                    nf;
        string                 line;
        ee_req_t               r;
        ee_rsp_t               got_rsp;
        ee_rsp_t               exp_rsp;
        bit                    ok;
        bit                    aborted;
        logic [31:0]           op_v;
        logic [31:0]           addr_v;
        logic [31:0]           wdata_v;
        logic [31:0]           fn_v;
        logic [31:0]           erd_v;
        logic [31:0]           enk_v;
        logic [`EE_ADDR_W-1:0] mem_addr;

        CLK         = 1'b0;
        RESET       = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        force_nack  = 1'b0;
        rand_state  = 32'd94;
        err_cnt     = 0;
        timeout_cnt = 0;
        req_cnt     = 0;
        aborted     = 1'b0;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            written[i] = 1'b0;

        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        fd = $fopen("test/eeprom_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file test/eeprom_stim.txt");
            err_cnt++;
        end
        else
        begin
            while (!aborted && $fgets(line, fd) > 0)
            begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                nf = $sscanf(line, "%h %h %h %h %h %h",
                             op_v, addr_v, wdata_v, fn_v, erd_v, enk_v);
                if (nf != 6)
                begin
                    $display("malformed stimulus line: %s", line);
                    err_cnt++;
                    continue;
                end
                r.op       = ee_op_e'(op_v[0]);
                r.addr     = addr_v[`EE_ADDR_W-1:0];
                r.wdata    = wdata_v[`EE_DATA_W-1:0];
                force_nack = fn_v[0];
                send_req(r, ok);
                if (!ok)
                begin
                    $display("timed out waiting for req_ready on request %0d", req_cnt);
                    timeout_cnt++;
                    aborted = 1'b1;
                    continue;
                end
                req_cnt++;
                get_rsp(got_rsp, ok);
                if (!ok)
                begin
                    $display("timed out waiting for a response to request %0d", req_cnt);
                    timeout_cnt++;
                    aborted = 1'b1;
                    continue;
                end
                exp_rsp = '{rdata: erd_v[`EE_DATA_W-1:0], nack: enk_v[0]};
                check_rsp(req_cnt, got_rsp, exp_rsp);
                if (r.op == EE_WRITE && !fn_v[0])
                begin
                    exp_mem[r.addr] = r.wdata;
                    written[r.addr] = 1'b1;
                end
            end
            $fclose(fd);
        end

        if (req_cnt == 0)
        begin
            $display("no request was run from the stimulus file");
            err_cnt++;
        end
        check_count(rsp_cnt, req_cnt);
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
        begin
            mem_addr = a[`EE_ADDR_W-1:0];
            if (written[a])
                check_mem(mem_addr, exp_mem[a]);
        end

        $display("errors: %0d  timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

// 24C16-style slave, oversamples the bus on CLK
module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,          // resolved line
    input  logic force_nack,   // refuse the control byte
    output logic pull          // 1 holds SDA low
);
    typedef enum logic [2:0] {
        M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RD_ACK, M_TX
    } mode_e;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W)-1];
    mode_e                 mode;
    logic [3:0]            bcnt;   // scl rises seen in this byte, 9 = ack slot done
    logic [7:0]            sh;
    logic [7:0]            tx;
    logic [`EE_ADDR_W-1:0] ptr;
    logic [2:0]            blk;
    logic                  scl_q;
    logic                  sda_q;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = '0;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            mode  <= M_IDLE;
            bcnt  <= '0;
            pull  <= 1'b0;
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda)   // start or repeated start
            begin
                mode <= M_CTRL;
                bcnt <= '0;
                pull <= 1'b0;
            end
            else if (scl_q && scl && !sda_q && sda)   // stop
            begin
                mode <= M_IDLE;
                bcnt <= '0;
                pull <= 1'b0;
            end
            else if (!scl_q && scl)
            begin
                if (bcnt < 4'd8)
                    sh <= {sh[6:0], sda};
                if (bcnt < 4'd9)
                    bcnt <= bcnt + 4'd1;
            end
            else if (scl_q && !scl)
            begin
                case (bcnt)
                    4'd8:
                    begin
                        pull <= 1'b0;   // stays released for the master ack in M_TX
                        case (mode)
                            M_CTRL:
                            begin
                                if (sh[7:4] == `EE_DEV_CODE && !force_nack)
                                begin
                                    pull <= 1'b1;
                                    blk  <= sh[3:1];
                                    mode <= sh[0] ? M_RD_ACK : M_ADDR;
                                    if (sh[0])
                                        ptr <= {sh[3:1], ptr[7:0]};
                                end
                                else
                                    mode <= M_IDLE;
                            end
                            M_ADDR:
                            begin
                                pull <= 1'b1;
                                ptr  <= {blk, sh};
                                mode <= M_WDATA;
                            end
                            M_WDATA:
                            begin
                                pull     <= 1'b1;
                                mem[ptr] <= sh;
                                mode     <= M_IDLE;   // no page writes
                            end
                            default:
                                ;
                        endcase
                    end
                    4'd9:
                    begin
                        bcnt <= '0;
                        pull <= 1'b0;
                        if (mode == M_RD_ACK)
                        begin
                            mode <= M_TX;
                            tx   <= mem[ptr];
                            pull <= !mem[ptr][7];
                        end
                        else if (mode == M_TX)
                            mode <= M_IDLE;
                    end
                    default:
                    begin
                        if (mode == M_TX && bcnt != 4'd0)
                            pull <= !tx[3'd7 - bcnt[2:0]];
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/eeprom_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_ctrl_top (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  eeprom_pkg::ee_req_t req,
    output logic                req_ready,
    output logic                rsp_valid,
    output eeprom_pkg::ee_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                scl,
    output logic                sda_oe,
    input  logic                sda_in
);
    import i2c_pkg::*;

    logic     cmd_valid;
    logic     cmd_ready;
    logic     res_valid;
    i2c_cmd_t cmd;
    i2c_res_t res;

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    i2c_bit_engine u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)   // resolved open-drain level
    );

endmodule

`default_nettype wire

// File: verilog/eeprom_seq.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module eeprom_seq (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  eeprom_pkg::ee_req_t req,
    output logic                req_ready,
    output logic                rsp_valid,
    output eeprom_pkg::ee_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                cmd_valid,
    output i2c_pkg::i2c_cmd_t   cmd,
    input  logic                cmd_ready,
    input  logic                res_valid,
    input  i2c_pkg::i2c_res_t   res
);
    import eeprom_pkg::*;
    import i2c_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_CTRL_W, S_ADDR, S_DATA_W,
        S_RSTART, S_CTRL_R, S_DATA_R, S_STOP, S_RESP
    } state_e;

    state_e                state;
    state_e                nxt;
    logic                  sent;      // command taken, waiting for its result
    ee_req_t               req_q;
    logic [`EE_DATA_W-1:0] rdata_q;
    logic                  nack_q;
    i2c_byte_u             ctrl_byte;

    assign req_ready = (state == S_IDLE);
    assign rsp_valid = (state == S_RESP);
    assign rsp       = '{rdata: rdata_q, nack: nack_q};
    assign cmd_valid = !sent && !(state inside {S_IDLE, S_RESP});

    always_comb
    begin
        ctrl_byte.ctrl.dev = `EE_DEV_CODE;
        ctrl_byte.ctrl.blk = req_q.addr[`EE_ADDR_W-1:8];
        ctrl_byte.ctrl.rw  = (state == S_CTRL_R);   // only the second control byte reads
        cmd = '0;
        case (state)
            S_START, S_RSTART:
                cmd.op = I2C_START;
            S_CTRL_W, S_CTRL_R:
            begin
                cmd.op   = I2C_WRITE;
                cmd.data = ctrl_byte;
            end
            S_ADDR:
            begin
                cmd.op       = I2C_WRITE;
                cmd.data.raw = req_q.addr[7:0];
            end
            S_DATA_W:
            begin
                cmd.op       = I2C_WRITE;
                cmd.data.raw = req_q.wdata;
            end
            S_DATA_R:
            begin
                cmd.op         = I2C_READ;
                cmd.master_ack = 1'b0;   // single byte ends with no-ack
            end
            default:
                cmd.op = I2C_STOP;
        endcase
    end

    // step taken when the engine reports back
    always_comb
    begin
        case (state)
            S_START:  nxt = S_CTRL_W;
            S_CTRL_W: nxt = S_ADDR;
            S_ADDR:   nxt = (req_q.op == EE_WRITE) ? S_DATA_W : S_RSTART;
            S_DATA_W: nxt = S_STOP;
            S_RSTART: nxt = S_CTRL_R;
            S_CTRL_R: nxt = S_DATA_R;
            S_DATA_R: nxt = S_STOP;
            S_STOP:   nxt = S_RESP;
            default:  nxt = S_IDLE;
        endcase
        if (!res.ack_ok && state != S_STOP)
            nxt = S_STOP;   // skip the rest of the transfer
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            sent   <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                sent <= 1'b1;
            case (state)
                S_IDLE:
                begin
                    if (req_valid)
                    begin
                        nack_q <= 1'b0;
                        state  <= S_START;
                    end
                end
                S_RESP:
                begin
                    if (rsp_ready)
                        state <= S_IDLE;
                end
                default:
                begin
                    if (res_valid)
                    begin
                        sent  <= 1'b0;
                        state <= nxt;
                        if (!res.ack_ok)
                            nack_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            req_q   <= req;
            rdata_q <= '0;
        end
        else if (state == S_DATA_R && res_valid)
            rdata_q <= res.rx;
    end

    a_idle_no_cmd: assert property (@(posedge CLK) disable iff (RESET)
        (state == S_IDLE) |-> (!sent && cmd_ready));

    a_one_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && !req_ready && $stable(rsp)));

endmodule

`default_nettype wire

// File: verilog/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module i2c_bit_engine (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  i2c_pkg::i2c_cmd_t cmd,
    output logic              cmd_ready,
    output logic              res_valid,
    output i2c_pkg::i2c_res_t res,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);
    import i2c_pkg::*;

    localparam int QW = (`EE_QTR > 1) ? $clog2(`EE_QTR) : 1;

    logic          busy;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic [3:0]    bitcnt;     // 0..7 data, 8 = ack slot
    i2c_cmd_e      op;
    logic          mack;
    logic [7:0]    shreg;      // tx bits out of the top, rx bits in at the bottom
    logic          qend;
    logic          last_bit;
    logic          done;
    logic [1:0]    nxt_phase;
    logic [3:0]    nxt_bit;

    // {scl, sda_oe} for the quarter being entered
    function automatic logic [1:0] drive(input i2c_cmd_e o, input logic [1:0] ph,
                                         input logic [3:0] b, input logic tx,
                                         input logic ma, input logic scl_now,
                                         input logic sda_now);
        logic sda;
        sda = sda_now;
        case (o)
            I2C_START:
            begin
                case (ph)
                    2'd0:    return {scl_now, 1'b0};
                    2'd1:    return 2'b10;
                    2'd2:    return 2'b11;   // sda falls, scl high
                    default: return 2'b01;
                endcase
            end
            I2C_STOP:
            begin
                case (ph)
                    2'd0:    return 2'b01;
                    2'd1:    return 2'b11;
                    default: return 2'b10;   // sda rises, scl high
                endcase
            end
            default:
            begin
                if (ph == 2'd0)
                begin
                    if (b == 4'd8)
                        sda = (o == I2C_READ) ? ma : 1'b0;
                    else
                        sda = (o == I2C_WRITE) ? !tx : 1'b0;
                end
                return {(ph == 2'd1 || ph == 2'd2), sda};
            end
        endcase
    endfunction

    assign qend      = busy && (qcnt == QW'(`EE_QTR - 1));
    assign last_bit  = (op == I2C_START) || (op == I2C_STOP) || (bitcnt == 4'd8);
    assign done      = qend && (phase == 2'd3) && last_bit;
    assign nxt_phase = phase + 2'd1;
    assign nxt_bit   = (phase == 2'd3) ? bitcnt + 4'd1 : bitcnt;
    assign cmd_ready = !busy;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            qcnt      <= '0;
            phase     <= '0;
            bitcnt    <= '0;
            op        <= I2C_STOP;
            mack      <= 1'b0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy   <= 1'b1;
                    qcnt   <= '0;
                    phase  <= '0;
                    bitcnt <= '0;
                    op     <= cmd.op;
                    mack   <= cmd.master_ack;
                    {scl, sda_oe} <= drive(cmd.op, 2'd0, 4'd0, cmd.data.raw[7],
                                           cmd.master_ack, scl, sda_oe);
                end
            end
            else if (qend)
            begin
                qcnt <= '0;
                if (done)
                begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                end
                else
                begin
                    phase  <= nxt_phase;
                    bitcnt <= nxt_bit;
                    {scl, sda_oe} <= drive(op, nxt_phase, nxt_bit, shreg[7], mack, scl, sda_oe);
                end
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    // sample point is the end of the first high quarter
    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            shreg      <= cmd.data.raw;
            res.ack_ok <= 1'b1;
        end
        else if (qend && phase == 2'd1)
        begin
            if (bitcnt != 4'd8)
                shreg <= {shreg[6:0], sda_in};
            else if (op == I2C_WRITE)
                res.ack_ok <= !sda_in;   // slave pulls low to ack
        end
        if (done)
            res.rx <= shreg;
    end

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        (busy && (op == I2C_WRITE || op == I2C_READ) && $changed(sda_oe))
            |-> (!scl && !$past(scl)));

    a_res_pulse: assert property (@(posedge CLK) disable iff (RESET)
        res_valid |=> !res_valid);

endmodule

`default_nettype wire

// File: verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef enum logic [1:0] {
        I2C_START = 2'd0,
        I2C_STOP  = 2'd1,
        I2C_WRITE = 2'd2,
        I2C_READ  = 2'd3
    } i2c_cmd_e;

    // control byte of a 24C16, block bits replace the pin address bits
    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] blk;   // address bits 10:8
        logic       rw;    // 1 = read
    } i2c_ctrl_t;

    typedef union packed {
        i2c_ctrl_t  ctrl;
        logic [7:0] raw;
    } i2c_byte_u;

    typedef struct packed {
        i2c_cmd_e  op;
        i2c_byte_u data;
        logic      master_ack;   // 1 pulls SDA low in the ninth bit of a read
    } i2c_cmd_t;

    typedef struct packed {
        logic [7:0] rx;
        logic       ack_ok;
    } i2c_res_t;

endpackage

`default_nettype wire

// File: verilog/eeprom_pkg.sv
`default_nettype none
`include "eeprom_params.svh"

package eeprom_pkg;

    typedef enum logic {
        EE_READ  = 1'b0,
        EE_WRITE = 1'b1
    } ee_op_e;

    // one single-byte host request
    typedef struct packed {
        ee_op_e                op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] wdata;   // ignored on reads
    } ee_req_t;

    typedef struct packed {
        logic [`EE_DATA_W-1:0] rdata;   // zero on writes and on nack
        logic                  nack;
    } ee_rsp_t;

endpackage

`default_nettype wire

// File: verilog/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// byte address into the 2 KB array, bits 10:8 go in the control byte
`define EE_ADDR_W 11

`define EE_DATA_W 8

// 24Cxx device type code
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of an SCL period
`define EE_QTR 4

`endif
